/* vlog.f */
+incdir+testbench
verilog/keystone_pkg.sv
verilog/h_matrix_regs.sv
verilog/projection_row.sv
verilog/perspective_divider.sv
verilog/keystone_correction.sv
testbench/tb_keystone.sv

/* Makefile */
# Verilator build and run of the keystone coordinate mapper testbench

VERILATOR ?= verilator
TOP       := tb_keystone
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(wildcard verilog/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_keystone_vectors.svh */
// Stimulus and expected results for the keystone testbench
// Coefficients are Q16.16 words in register order a to h
// Expected pixels round num / w half away from zero, then add the centre
// A probe with probe_err set must see pslverr, read zero and leave H alone
`ifndef TB_KEYSTONE_VECTORS_SVH
`define TB_KEYSTONE_VECTORS_SVH

typedef logic [0:7][31:0] matrix_t;

// Columns: coeff a..h, dst x y, expected src x y, in_bounds, probe address, probe error
typedef struct packed {
    matrix_t     coeff;
    logic [15:0] dst_x;
    logic [15:0] dst_y;
    logic [15:0] src_x;
    logic [15:0] src_y;
    logic        in_bounds;
    logic [7:0]  probe_addr;
    logic        probe_err;
} vector_t;

localparam int NUM_VECTORS = 13;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    // Identity at both corners and the centre
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd0, 16'd0, 16'd0, 16'd0, 1'b1, 8'h20, 1'b1},
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd1919, 16'd1079, 16'd1919, 16'd1079, 1'b1, 8'h1C, 1'b0},
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd960, 16'd540, 16'd960, 16'd540, 1'b1, 8'h40, 1'b1},
    // Shift by +10 in x and -5 in y
    '{'{32'h10000, 32'h0, 32'hA0000, 32'h0, 32'h10000, 32'hFFFB0000, 32'h0, 32'h0},
      16'd100, 16'd200, 16'd110, 16'd195, 1'b1, 8'h08, 1'b0},
    // Half scale in x; +0.5 and -0.5 round away from the centre
    '{'{32'h8000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd961, 16'd100, 16'd961, 16'd100, 1'b1, 8'h22, 1'b1},
    '{'{32'h8000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd959, 16'd1000, 16'd959, 16'd1000, 1'b1, 8'h14, 1'b0},
    '{'{32'h8000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd0, 16'd540, 16'd480, 16'd540, 1'b1, 8'hFC, 1'b1},
    // c of 0.5 gives -859.5, rounded to -860
    '{'{32'h10000, 32'h0, 32'h8000, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h0},
      16'd100, 16'd300, 16'd100, 16'd300, 1'b1, 8'h00, 1'b0},
    // g = 1/1024, w = 1.5 and 512 / 1.5 = 341.33
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h40, 32'h0},
      16'd1472, 16'd540, 16'd1301, 16'd540, 1'b1, 8'h18, 1'b0},
    // h = 1/512, w = 1.5 and 256 / 1.5 = 170.67
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h0, 32'h80},
      16'd960, 16'd796, 16'd960, 16'd711, 1'b1, 8'h20, 1'b1},
    // g = -1/256 makes w = -1 and mirrors x
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'hFFFFFF00, 32'h0},
      16'd1472, 16'd540, 16'd448, 16'd540, 1'b1, 8'h80, 1'b1},
    // w = -0.875 pushes x to 2057, then w = 0
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h80, 32'h0},
      16'd0, 16'd540, 16'd0, 16'd0, 1'b0, 8'h0C, 1'b0},
    '{'{32'h10000, 32'h0, 32'h0, 32'h0, 32'h10000, 32'h0, 32'h80, 32'h0},
      16'd448, 16'd540, 16'd0, 16'd0, 1'b0, 8'h20, 1'b1}
};

`endif

/* testbench/tb_keystone.sv */
// Testbench for the keystone coordinate mapper
// Per table row: program H over APB, probe one offset, read H back,
// then map one pixel and check the result, its latency and coord_ready
// Inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_keystone;

    localparam int CLOCK_PERIOD = 100;
    localparam int WAIT_LIMIT   = keystone_pkg::RESULT_LATENCY + 40;
    // Busy cycles for which an accepted coordinate stays valid
    localparam int HOLD_CYCLES  = 4;

    `include "tb_keystone_vectors.svh"

    logic                                    clock;
    logic                                    reset;
    logic [keystone_pkg::APB_ADDR_WIDTH-1:0] paddr;
    logic                                    psel, penable, pwrite;
    logic [31:0]                             pwdata, prdata;
    logic                                    pready, pslverr;
    logic                                    coord_valid, coord_ready;
    keystone_pkg::coord_t                    dst_x, dst_y, src_x, src_y;
    logic                                    result_valid, in_bounds;
    int                                      edges = 0;
    int                                      result_count = 0;

    keystone_correction i_keystone_correction (
        .clock (clock), .reset (reset),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .coord_valid (coord_valid), .dst_x (dst_x), .dst_y (dst_y),
        .coord_ready (coord_ready), .result_valid (result_valid),
        .src_x (src_x), .src_y (src_y), .in_bounds (in_bounds)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Rising edge count, base of the latency check
    always @(posedge clock) begin
        edges <= edges + 1;
    end

    // A coordinate taken twice would add a pulse here
    always @(negedge clock) begin
        if (result_valid === 1'b1) begin
            result_count <= result_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic compare_values(input logic signed [63:0] actual,
                                  input logic signed [63:0] expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t: %s, got %0d, expected %0d",
                                $time, what, actual, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // APB and coordinate drivers
    ////////////////////////////////////////////////////////////////////

    task automatic apb_transfer(input logic [7:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clock);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clock);
        penable <= 1'b1;
        // Response is stable through the access phase
        @(negedge clock);
        compare_values(64'(pready), 64'd1, "pready in access phase");
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic program_matrix(input matrix_t coeff);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            apb_transfer(8'(4 * i), 1'b1, coeff[i], rdata, err);
            compare_values(64'(err), 64'd0, "pslverr on coefficient write");
        end
    endtask

    task automatic verify_matrix(input matrix_t coeff);
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            apb_transfer(8'(4 * i), 1'b0, 32'h0, rdata, err);
            compare_values(64'(err), 64'd0, "pslverr on coefficient read");
            compare_values(64'(rdata), 64'(coeff[i]), $sformatf("read back of H entry %0d", i));
        end
    endtask

    // Unmapped probes also get a write that must not land
    task automatic probe_address(input vector_t vec);
        logic [31:0] rdata;
        logic [31:0] expected;
        logic        err;
        if (vec.probe_err) begin
            apb_transfer(vec.probe_addr, 1'b1, 32'hdead_beef, rdata, err);
            compare_values(64'(err), 64'd1, "pslverr on probe write");
        end
        apb_transfer(vec.probe_addr, 1'b0, 32'h0, rdata, err);
        compare_values(64'(err), 64'(vec.probe_err), "pslverr on probe read");
        expected = vec.probe_err ? 32'h0 : vec.coeff[vec.probe_addr[4:2]];
        compare_values(64'(rdata), 64'(expected), "probe read data");
    endtask

    task automatic map_coordinate(input vector_t vec);
        int waited;
        int accept_edge;
        @(posedge clock);
        coord_valid <= 1'b1;
        dst_x       <= keystone_pkg::coord_t'(vec.dst_x);
        dst_y       <= keystone_pkg::coord_t'(vec.dst_y);
        waited = 0;
        @(negedge clock);
        while (coord_ready !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timed out waiting for coord_ready");
            end
            @(negedge clock);
        end
        // Acceptance edge
        @(posedge clock);
        @(negedge clock);
        accept_edge = edges;
        waited = 0;
        while (result_valid !== 1'b1) begin
            compare_values(64'(coord_ready), 64'd0, "coord_ready while busy");
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("Timed out waiting for result_valid");
            end
            @(posedge clock);
            if (waited == HOLD_CYCLES) begin
                coord_valid <= 1'b0;
            end
            @(negedge clock);
        end
        compare_values(64'(edges - accept_edge), 64'(keystone_pkg::RESULT_LATENCY),
                       "edges from acceptance to result_valid");
        compare_values(64'(coord_ready), 64'd1, "coord_ready with result_valid");
        compare_values(64'(src_x), 64'(vec.src_x), "src_x");
        compare_values(64'(src_y), 64'(vec.src_y), "src_y");
        compare_values(64'(in_bounds), 64'(vec.in_bounds), "in_bounds");
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin
        reset       <= 1'b1;
        paddr       <= '0;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        pwdata      <= '0;
        coord_valid <= 1'b0;
        dst_x       <= '0;
        dst_y       <= '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_values(64'(coord_ready), 64'd1, "coord_ready after reset");
        compare_values(64'(result_valid), 64'd0, "result_valid after reset");
        compare_values(64'(pslverr), 64'd0, "pslverr after reset");
        verify_matrix('0);
        for (int row = 0; row < NUM_VECTORS; row++) begin
            program_matrix(VECTORS[row].coeff);
            probe_address(VECTORS[row]);
            verify_matrix(VECTORS[row].coeff);
            map_coordinate(VECTORS[row]);
        end
        // Time for a stray second result to appear
        repeat (keystone_pkg::RESULT_LATENCY + 2) @(negedge clock);
        if (result_count == NUM_VECTORS) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("Got %0d results for %0d coordinates", result_count,
                                NUM_VECTORS));
        end
    end

    initial begin
        #(NUM_VECTORS * (keystone_pkg::RESULT_LATENCY + 40) * CLOCK_PERIOD * 2);
        abort_run("Watchdog expired before the test finished");
    end

endmodule

/* verilog/keystone_correction.sv */
// Keystone coordinate mapper top level
// Maps a destination pixel to its source pixel through the H matrix
// Only one coordinate is in flight; coord_ready stays low until its result
// The result port has no back-pressure and holds result_valid for one cycle
`timescale 1ns/1ps

module keystone_correction (
    input  logic                                      clock,
    input  logic                                      reset,
    // APB slave
    input  logic [keystone_pkg::APB_ADDR_WIDTH-1:0]   paddr,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [31:0]                               pwdata,
    output logic [31:0]                               prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    // Coordinate input
    input  logic                                      coord_valid,
    input  keystone_pkg::coord_t                      dst_x,
    input  keystone_pkg::coord_t                      dst_y,
    output logic                                      coord_ready,
    // Result output
    output logic                                      result_valid,
    output keystone_pkg::coord_t                      src_x,
    output keystone_pkg::coord_t                      src_y,
    output logic                                      in_bounds
);

    keystone_pkg::coeff_t coeff_a, coeff_b, coeff_c, coeff_d;
    keystone_pkg::coeff_t coeff_e, coeff_f, coeff_g, coeff_h;
    keystone_pkg::acc_t   sum_x, sum_y, sum_w;
    logic                 sum_valid;
    logic                 accept;

    // Handshake of the coordinate port
    assign accept = coord_valid & coord_ready;

    h_matrix_regs i_h_matrix_regs (
        .clock   (clock),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .coeff_a (coeff_a),
        .coeff_b (coeff_b),
        .coeff_c (coeff_c),
        .coeff_d (coeff_d),
        .coeff_e (coeff_e),
        .coeff_f (coeff_f),
        .coeff_g (coeff_g),
        .coeff_h (coeff_h)
    );

    //////////////////////////////////////////////////////////////////////
    // Three rows of the projective product
    //////////////////////////////////////////////////////////////////////

    // Valid of the x and y rows matches the w row and is left open
    projection_row row_x (
        .clock (clock), .reset (reset), .accept (accept),
        .dst_x (dst_x), .dst_y (dst_y),
        .coeff_x (coeff_a), .coeff_y (coeff_b), .coeff_c (coeff_c),
        .row_sum (sum_x), .row_valid ()
    );

    projection_row row_y (
        .clock (clock), .reset (reset), .accept (accept),
        .dst_x (dst_x), .dst_y (dst_y),
        .coeff_x (coeff_d), .coeff_y (coeff_e), .coeff_c (coeff_f),
        .row_sum (sum_y), .row_valid ()
    );

    // Implied ninth entry of H is one
    projection_row #(.USE_UNIT_OFFSET(1)) row_w (
        .clock (clock), .reset (reset), .accept (accept),
        .dst_x (dst_x), .dst_y (dst_y),
        .coeff_x (coeff_g), .coeff_y (coeff_h), .coeff_c (keystone_pkg::H_ONE),
        .row_sum (sum_w), .row_valid (sum_valid)
    );

    perspective_divider i_perspective_divider (
        .clock        (clock),
        .reset        (reset),
        .row_valid    (sum_valid),
        .num_x        (sum_x),
        .num_y        (sum_y),
        .den_w        (sum_w),
        .coord_ready  (coord_ready),
        .result_valid (result_valid),
        .src_x        (src_x),
        .src_y        (src_y),
        .in_bounds    (in_bounds)
    );

endmodule

/* verilog/perspective_divider.sv */
// Divides the x and y row sums by the w row sum and maps back to pixels
// Two restoring dividers share one FSM and run DIV_STEPS cycles in lockstep
// Quotient of 2|num| by |w| is halved after adding one, rounding half away from zero
// Row sums must keep their magnitude below 2**47 and DIV_STEPS is at most 64
// Out-of-frame results and w of zero give in_bounds low and zero coordinates
`timescale 1ns/1ps

module perspective_divider (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 row_valid,
    input  keystone_pkg::acc_t   num_x,
    input  keystone_pkg::acc_t   num_y,
    input  keystone_pkg::acc_t   den_w,
    output logic                 coord_ready,
    output logic                 result_valid,
    output keystone_pkg::coord_t src_x,
    output keystone_pkg::coord_t src_y,
    output logic                 in_bounds
);

    keystone_pkg::div_state_t                  state;
    logic [5:0]                                step_count;
    logic [keystone_pkg::ACC_WIDTH-1:0]        divisor;
    logic [keystone_pkg::ACC_WIDTH-1:0]        rem_x, quo_x, rem_y, quo_y;
    logic                                      neg_x, neg_y, w_zero;
    logic signed [keystone_pkg::ACC_WIDTH+1:0] pos_x, pos_y;
    logic                                      x_ok, y_ok, fits;

    //////////////////////////////////////////////////////////////////////
    // Arithmetic helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [keystone_pkg::ACC_WIDTH-1:0] magnitude(
        input keystone_pkg::acc_t value
    );
        logic [keystone_pkg::ACC_WIDTH-1:0] mag;
        mag = value;
        if (value[keystone_pkg::ACC_WIDTH-1]) begin
            mag = -value;
        end
        return mag;
    endfunction

    // One restoring step; next dividend bit shifts out of the quotient MSB
    function automatic logic [2*keystone_pkg::ACC_WIDTH-1:0] div_step(
        input logic [keystone_pkg::ACC_WIDTH-1:0] rem,
        input logic [keystone_pkg::ACC_WIDTH-1:0] quo,
        input logic [keystone_pkg::ACC_WIDTH-1:0] dvs
    );
        logic [keystone_pkg::ACC_WIDTH:0] shifted;
        logic [keystone_pkg::ACC_WIDTH:0] diff;
        shifted = {rem, quo[keystone_pkg::ACC_WIDTH-1]};
        diff    = shifted - {1'b0, dvs};
        // Borrow means the trial subtract failed
        if (diff[keystone_pkg::ACC_WIDTH]) begin
            return {shifted[keystone_pkg::ACC_WIDTH-1:0],
                    quo[keystone_pkg::ACC_WIDTH-2:0], 1'b0};
        end
        return {diff[keystone_pkg::ACC_WIDTH-1:0], quo[keystone_pkg::ACC_WIDTH-2:0], 1'b1};
    endfunction

    // Round, apply the sign and move back to frame coordinates
    function automatic logic signed [keystone_pkg::ACC_WIDTH+1:0] finish(
        input logic [keystone_pkg::ACC_WIDTH-1:0] quo,
        input logic                               neg,
        input int                                 centre
    );
        logic [keystone_pkg::ACC_WIDTH:0]          rounded;
        logic signed [keystone_pkg::ACC_WIDTH+1:0] mag;
        rounded = ({1'b0, quo} + 1'b1) >> 1;
        mag     = $signed({1'b0, rounded});
        return (neg ? -mag : mag) + centre;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Control FSM and result registers
    //////////////////////////////////////////////////////////////////////

    // Accept a new coordinate only when nothing is queued or running
    assign coord_ready = (state == keystone_pkg::DIV_IDLE) && !row_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= keystone_pkg::DIV_IDLE;
            step_count   <= '0;
            result_valid <= 1'b0;
            src_x        <= '0;
            src_y        <= '0;
            in_bounds    <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                keystone_pkg::DIV_IDLE: begin
                    if (row_valid) begin
                        state      <= keystone_pkg::DIV_RUN;
                        step_count <= '0;
                    end
                end
                keystone_pkg::DIV_RUN: begin
                    step_count <= step_count + 1'b1;
                    if (step_count == 6'(keystone_pkg::DIV_STEPS - 1)) begin
                        state <= keystone_pkg::DIV_ROUND;
                    end
                end
                keystone_pkg::DIV_ROUND: begin
                    state        <= keystone_pkg::DIV_IDLE;
                    result_valid <= 1'b1;
                    in_bounds    <= fits;
                    // Zero coordinates when the point misses the frame
                    src_x        <= fits ? keystone_pkg::coord_t'(pos_x[15:0]) : '0;
                    src_y        <= fits ? keystone_pkg::coord_t'(pos_y[15:0]) : '0;
                end
                default: begin
                    state <= keystone_pkg::DIV_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Divider datapath
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (state == keystone_pkg::DIV_IDLE && row_valid) begin
            // Signs kept aside, dividers work on magnitudes
            neg_x   <= num_x[keystone_pkg::ACC_WIDTH-1] ^ den_w[keystone_pkg::ACC_WIDTH-1];
            neg_y   <= num_y[keystone_pkg::ACC_WIDTH-1] ^ den_w[keystone_pkg::ACC_WIDTH-1];
            w_zero  <= (den_w == '0);
            divisor <= magnitude(den_w);
            // Doubled numerator gives one extra quotient bit for rounding
            quo_x   <= magnitude(num_x) << 1;
            quo_y   <= magnitude(num_y) << 1;
            rem_x   <= '0;
            rem_y   <= '0;
        end else if (state == keystone_pkg::DIV_RUN) begin
            {rem_x, quo_x} <= div_step(rem_x, quo_x, divisor);
            {rem_y, quo_y} <= div_step(rem_y, quo_y, divisor);
        end
    end

    // Wide results so a small w cannot wrap into the frame
    assign pos_x = finish(quo_x, neg_x, keystone_pkg::CENTER_X);
    assign pos_y = finish(quo_y, neg_y, keystone_pkg::CENTER_Y);

    assign x_ok = (pos_x >= 0) && (pos_x < keystone_pkg::FRAME_WIDTH);
    assign y_ok = (pos_y >= 0) && (pos_y < keystone_pkg::FRAME_HEIGHT);
    assign fits = x_ok && y_ok && !w_zero;

    // Row sums only arrive while the divider is free
    row_valid_when_idle: assert property (
        @(posedge clock) disable iff (reset)
        row_valid |-> state == keystone_pkg::DIV_IDLE
    );

    result_valid_single: assert property (
        @(posedge clock) disable iff (reset)
        result_valid |=> !result_valid
    );

endmodule

/* verilog/projection_row.sv */
// One row of the H product on a centred destination pixel
// row_sum = coeff_x * (x - CENTER_X) + coeff_y * (y - CENTER_Y) + offset
// The offset is coeff_c, or 1.0 when USE_UNIT_OFFSET is set
// All terms carry the Q16.16 scale of the coefficients
`timescale 1ns/1ps

module projection_row #(
    parameter bit USE_UNIT_OFFSET = 1'b0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 accept,
    input  keystone_pkg::coord_t dst_x,
    input  keystone_pkg::coord_t dst_y,
    input  keystone_pkg::coeff_t coeff_x,
    input  keystone_pkg::coeff_t coeff_y,
    input  keystone_pkg::coeff_t coeff_c,
    output keystone_pkg::acc_t   row_sum,
    output logic                 row_valid
);

    keystone_pkg::coord_t x_centred, y_centred;
    keystone_pkg::acc_t   prod_x, prod_y, offset, sum;

    // Move the origin to the frame centre
    assign x_centred = dst_x - keystone_pkg::coord_t'(keystone_pkg::CENTER_X);
    assign y_centred = dst_y - keystone_pkg::coord_t'(keystone_pkg::CENTER_Y);

    // Sign-extended multiply; integer pixel times Q16.16 stays Q16.16
    assign prod_x = keystone_pkg::acc_t'(coeff_x) * keystone_pkg::acc_t'(x_centred);
    assign prod_y = keystone_pkg::acc_t'(coeff_y) * keystone_pkg::acc_t'(y_centred);

    // w row has its constant fixed at one
    assign offset = USE_UNIT_OFFSET ? keystone_pkg::acc_t'(keystone_pkg::H_ONE)
                                    : keystone_pkg::acc_t'(coeff_c);

    assign sum = prod_x + prod_y + offset;

    // Sum captured with the coordinate
    always_ff @(posedge clock) begin
        if (accept) begin
            row_sum <= sum;
        end
    end

    // One-cycle strobe after acceptance
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            row_valid <= 1'b0;
        end else begin
            row_valid <= accept;
        end
    end

endmodule

/* verilog/h_matrix_regs.sv */
// APB register bank for the eight H coefficients a to h
// Word offsets 0x00 to 0x1C; no wait states, pready is tied high
// Other or unaligned addresses end with pslverr, read zero and write nothing
// Writes land at the edge that closes the access phase
`timescale 1ns/1ps

module h_matrix_regs (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [keystone_pkg::APB_ADDR_WIDTH-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [31:0]                             pwdata,
    output logic [31:0]                             prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    output keystone_pkg::coeff_t                    coeff_a,
    output keystone_pkg::coeff_t                    coeff_b,
    output keystone_pkg::coeff_t                    coeff_c,
    output keystone_pkg::coeff_t                    coeff_d,
    output keystone_pkg::coeff_t                    coeff_e,
    output keystone_pkg::coeff_t                    coeff_f,
    output keystone_pkg::coeff_t                    coeff_g,
    output keystone_pkg::coeff_t                    coeff_h
);

    keystone_pkg::coeff_t     coeff_q [0:7];
    keystone_pkg::h_index_t   index;
    logic                     mapped;
    logic                     access;
    logic                     write_en;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    // Upper bits and byte lane bits must be zero
    assign mapped = (paddr[keystone_pkg::APB_ADDR_WIDTH-1:5] == '0) && (paddr[1:0] == 2'b00);
    assign index  = keystone_pkg::h_index_t'(paddr[4:2]);

    // Second cycle of a transfer
    assign access   = psel & penable;
    assign write_en = access & pwrite & mapped;

    //////////////////////////////////////////////////////////////////////
    // Coefficient storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            coeff_q <= '{default: '0};
        end else if (write_en) begin
            coeff_q[index] <= pwdata;
        end
    end

    // Read mux; unmapped offsets return zero
    assign prdata  = mapped ? coeff_q[index] : '0;
    assign pslverr = access & ~mapped;
    assign pready  = 1'b1;

    assign coeff_a = coeff_q[keystone_pkg::H_A];
    assign coeff_b = coeff_q[keystone_pkg::H_B];
    assign coeff_c = coeff_q[keystone_pkg::H_C];
    assign coeff_d = coeff_q[keystone_pkg::H_D];
    assign coeff_e = coeff_q[keystone_pkg::H_E];
    assign coeff_f = coeff_q[keystone_pkg::H_F];
    assign coeff_g = coeff_q[keystone_pkg::H_G];
    assign coeff_h = coeff_q[keystone_pkg::H_H];

    // Access phase always follows a setup phase
    apb_setup_before_access: assert property (
        @(posedge clock) disable iff (reset)
        $rose(penable) |-> psel && $past(psel)
    );

endmodule

/* verilog/keystone_pkg.sv */
// Shared constants and types for the keystone coordinate mapper
// Coefficients are signed Q16.16 and the row sums carry the same scale
// Destination and source coordinates are signed 16-bit pixel indices
// A row sum is assumed to keep its magnitude below 2**47
package keystone_pkg;

    //////////////////////////////////////////////////////////////////////
    // Frame geometry
    //////////////////////////////////////////////////////////////////////

    localparam int FRAME_WIDTH  = 1920;
    localparam int FRAME_HEIGHT = 1080;
    localparam int CENTER_X     = FRAME_WIDTH / 2;
    localparam int CENTER_Y     = FRAME_HEIGHT / 2;

    //////////////////////////////////////////////////////////////////////
    // Number formats and widths
    //////////////////////////////////////////////////////////////////////

    localparam int H_FRAC_BITS    = 16;
    localparam int ACC_WIDTH      = 48;
    localparam int APB_ADDR_WIDTH = 8;

    // One divider iteration per bit of the doubled numerator magnitude
    localparam int DIV_STEPS      = ACC_WIDTH;
    // Row register, divider load, iterations and rounding register
    localparam int RESULT_LATENCY = DIV_STEPS + 2;

    typedef logic signed [31:0]          coeff_t;
    typedef logic signed [15:0]          coord_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // 1.0 in Q16.16
    localparam coeff_t H_ONE = coeff_t'(1) <<< H_FRAC_BITS;

    //////////////////////////////////////////////////////////////////////
    // Enumerations
    //////////////////////////////////////////////////////////////////////

    // APB word offset of each H entry
    typedef enum logic [2:0] {
        H_A = 3'd0,
        H_B = 3'd1,
        H_C = 3'd2,
        H_D = 3'd3,
        H_E = 3'd4,
        H_F = 3'd5,
        H_G = 3'd6,
        H_H = 3'd7
    } h_index_t;

    typedef enum logic [1:0] {
        DIV_IDLE  = 2'd0,
        DIV_RUN   = 2'd1,
        DIV_ROUND = 2'd2
    } div_state_t;

endpackage
